// ==== all.f ====
+incdir+design
design/trig_pkg.sv
design/event_fifo.sv
design/trigger_receiver.sv
design/channel_acq_controller.sv
design/trigger_processor.sv
design/trigger_top.sv
tb/trigger_tb.sv

// ==== Bender.yml ====
package:
  name: trigger_path

sources:
  - include_dirs:
      - design
    files:
      - design/trig_pkg.sv
      - design/event_fifo.sv
      - design/trigger_receiver.sv
      - design/channel_acq_controller.sv
      - design/trigger_processor.sv
      - design/trigger_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/trigger_tb.sv

// ==== tb/trigger_tb.sv ====
// random-stimulus testbench for trigger_top, checks numbering, fan-out, readout and drops
`timescale 1ns/1ps
`include "trig_consts.svh"

module trigger_tb;
    localparam int PERIOD       = 8;
    localparam int N_TRIG       = 40;
    localparam int CYC_PER_TRIG = 80; // delay 17, dones 8, readout gaps, idle gap

    logic                    ttc_clk, rst, rst_trigger_num, rst_trigger_timestamp;
    logic                    ttc_trigger, readout_ready, readout_done;
    logic [`TRIG_TYPE_W-1:0] trig_type, ttc_trig_type;
    logic [`N_CHAN-1:0]      chan_en, chan_dones, chan_enable, chan_trig;
    logic [`DELAY_W-1:0]     trig_delay;
    logic                    send_empty_event, initiate_readout;
    logic [`TRIG_NUM_W-1:0]  ttc_event_num, ttc_trig_num, trig_num;
    logic [`TSTAMP_W-1:0]    ttc_trig_timestamp, trig_timestamp;
    logic                    trig_fifo_full, acq_fifo_full;
    logic                    error_trig_rate, error_trig_num, error_trig_type;

    logic [15:0]             lfsr = 16'd45;
    int                      cyc = 0;          // posedge count
    int                      checks, mismatches, failures;
    int                      model_num, exp_event;
    int                      ts_base;          // cycle of reset release
    bit                      rate_err;         // model of the sticky rate flag
    int                      num_q[$];         // expected records, oldest first
    logic [`TRIG_TYPE_W-1:0] type_q[$];
    logic [`TSTAMP_W-1:0]    ts_q[$];

    trigger_top UUT (.*);

    always #(PERIOD / 2) ttc_clk = ~ttc_clk;
    always @(posedge ttc_clk) cyc <= cyc + 1;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [7:0] next_bits(input int n);
        logic [7:0] val;
        int         i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val  = {val[6:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                                 input string what);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            failures++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    // quiet gap, nothing may fire or be requested
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge ttc_clk);
            expect_true(!initiate_readout && !send_empty_event, "request with no trigger sent");
            expect_true(chan_trig == '0, "channel fired with no trigger sent");
            compare_value({trig_fifo_full, acq_fifo_full}, 0, "fifo half-full flags");
        end
    endtask

    task automatic reset_numbering();
        @(negedge ttc_clk);
        rst_trigger_num = 1'b1;
        @(negedge ttc_clk);
        rst_trigger_num = 1'b0;
        model_num       = 0;  // next trigger is number 1 again
        compare_value(trig_num, 0, "trig_num after counter reset");
    endtask

    // one trigger from the ttc to the readout handshake, optional second one to drop
    task automatic send_trigger(input bit drop_next);
        logic [`TRIG_TYPE_W-1:0] ty;
        logic [`N_CHAN-1:0]      en;
        logic [`DELAY_W-1:0]     dly;
        logic [`N_CHAN-1:0]      pend; // enabled channels not done yet
        int                      cnt [`N_CHAN];
        int                      t0;
        bit                      fired, seen;
        ty    = `TRIG_TYPE_W'(next_bits(3));
        en    = `N_CHAN'(next_bits(5));
        if (next_bits(2) == 0)
            en = '0;                       // empty event about one time in four
        dly   = `DELAY_W'(next_bits(4));
        pend  = '0;
        fired = 1'b0;
        seen  = 1'b0;
        @(negedge ttc_clk);
        ttc_trigger = 1'b1;
        trig_type   = ty;
        chan_en     = en;
        trig_delay  = dly;
        t0          = cyc;                 // sampled at edge t0 + 1
        model_num++;
        num_q.push_back(model_num);
        type_q.push_back(ty);
        ts_q.push_back(t0 - ts_base);      // ticks since reset release
        while (!seen) begin
            @(negedge ttc_clk);
            ttc_trigger   = 1'b0;
            chan_dones    = '0;
            readout_ready = (next_bits(2) != 0); // random stalls
            if (cyc == t0 + 1) begin
                compare_value(trig_num, model_num, "trig_num after trigger");
                compare_value(trig_timestamp, t0 - ts_base, "trig_timestamp after trigger");
            end
            if (drop_next && cyc == t0 + 1) begin
                ttc_trigger = 1'b1;        // next edge, request still in flight
                model_num++;
                rate_err    = 1'b1;
            end
            if (drop_next && cyc == t0 + 2) begin
                compare_value(trig_num, model_num, "trig_num after dropped trigger");
                compare_value(trig_timestamp, t0 + 1 - ts_base,
                              "trig_timestamp after dropped trigger");
                compare_value(error_trig_rate, 1, "error_trig_rate after drop");
            end
            // channel fan-out
            if (chan_trig != '0) begin
                expect_true(!fired, "chan_trig pulsed twice for one trigger");
                compare_value(cyc - t0 - 1, dly + 2, "chan_trig delay in cycles");
                compare_value(chan_trig, en, "chan_trig mask");
                compare_value(chan_enable, en, "chan_enable at fire");
                fired = 1'b1;
                for (int ch = 0; ch < `N_CHAN; ch++) begin
                    pend[ch] = en[ch];
                    cnt[ch]  = next_bits(3); // done 1 to 8 cycles after fire
                end
            end else begin
                for (int ch = 0; ch < `N_CHAN; ch++) begin
                    if (pend[ch] && cnt[ch] == 0) begin
                        chan_dones[ch] = 1'b1;
                        pend[ch]       = 1'b0;
                    end else if (pend[ch]) begin
                        cnt[ch]--;
                    end
                end
            end
            // readout or empty event
            if (initiate_readout || send_empty_event) begin
                seen = 1'b1;
                compare_value(ttc_trig_num, num_q.pop_front(), "ttc_trig_num");
                compare_value(ttc_trig_type, type_q.pop_front(), "ttc_trig_type");
                compare_value(ttc_trig_timestamp, ts_q.pop_front(), "ttc_trig_timestamp");
                exp_event++;
                compare_value(ttc_event_num, exp_event, "ttc_event_num");
                compare_value(initiate_readout, en != '0, "initiate_readout");
                compare_value(send_empty_event, en == '0, "send_empty_event");
                compare_value(fired, en != '0, "channels fired before request");
                compare_value(pend, 0, "dones outstanding at readout");
                compare_value(error_trig_rate, rate_err, "error_trig_rate");
                compare_value(error_trig_num, 0, "error_trig_num");
                compare_value(error_trig_type, 0, "error_trig_type");
                readout_done = 1'b1;       // command manager answers at once
            end
        end
        @(negedge ttc_clk);
        readout_done = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------------------
    initial begin
        #((N_TRIG + 4) * CYC_PER_TRIG * PERIOD);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("=== FAIL ===");
        $finish;
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        ttc_clk               = 1'b0;
        rst                   = 1'b1;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        ttc_trigger           = 1'b0;
        trig_type             = '0;
        chan_en               = '0;
        trig_delay            = '0;
        chan_dones            = '0;
        readout_ready         = 1'b1;
        readout_done          = 1'b0;
        checks                = 0;
        mismatches            = 0;
        failures              = 0;
        model_num             = 0;
        exp_event             = 0;
        ts_base               = 0;
        rate_err              = 1'b0;
        repeat (2) @(negedge ttc_clk);
        compare_value({chan_trig, chan_enable}, 0, "channel outputs in reset");
        compare_value({initiate_readout, send_empty_event}, 0, "requests in reset");
        compare_value({error_trig_rate, error_trig_num, error_trig_type}, 0, "errors in reset");
        compare_value(trig_num, 0, "trig_num in reset");
        compare_value(trig_timestamp, 0, "trig_timestamp in reset");
        rst     = 1'b0;
        ts_base = cyc;                     // timestamp counts from the next edge
        idle_cycles(3);
        for (int i = 0; i < N_TRIG; i++) begin
            if (i == 24)
                reset_numbering();
            send_trigger(i == 7 || i == 19 || i == 31);
            idle_cycles(2 + next_bits(2));
        end
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== design/trigger_top.sv ====
// top of the synchronous trigger path, wires receiver, controller, processor and two fifos
`timescale 1ns/1ps
`include "trig_consts.svh"

module trigger_top (
    input  logic                     ttc_clk,
    input  logic                     rst,
    input  logic                     rst_trigger_num,
    input  logic                     rst_trigger_timestamp,
    input  logic                     ttc_trigger,
    input  logic [`TRIG_TYPE_W-1:0]  trig_type,
    input  logic [`N_CHAN-1:0]       chan_en,
    input  logic [`DELAY_W-1:0]      trig_delay,
    input  logic [`N_CHAN-1:0]       chan_dones,
    output logic [`N_CHAN-1:0]       chan_enable,
    output logic [`N_CHAN-1:0]       chan_trig,
    input  logic                     readout_ready,
    input  logic                     readout_done,
    output logic                     send_empty_event,
    output logic                     initiate_readout,
    output logic [`TRIG_NUM_W-1:0]   ttc_event_num,
    output logic [`TRIG_NUM_W-1:0]   ttc_trig_num,
    output logic [`TRIG_TYPE_W-1:0]  ttc_trig_type,
    output logic [`TSTAMP_W-1:0]     ttc_trig_timestamp,
    output logic [`TRIG_NUM_W-1:0]   trig_num,
    output logic [`TSTAMP_W-1:0]     trig_timestamp,
    output logic                     trig_fifo_full,  // half full
    output logic                     acq_fifo_full,   // half full
    output logic                     error_trig_rate,
    output logic                     error_trig_num,
    output logic                     error_trig_type
);
    import trig_pkg::*;

    // ----------------------------------------------------------------------
    // internal links
    // ----------------------------------------------------------------------
    acq_req_t  acq_req;
    logic      acq_ready;
    logic      trig_push, trig_valid, trig_pop, trig_credit;
    trig_rec_t trig_rec, trig_head;
    logic      acq_push, acq_valid, acq_pop, acq_credit;
    acq_rec_t  acq_rec, acq_head;

    trigger_receiver u_receiver (
        .ttc_clk, .rst, .rst_trigger_num, .rst_trigger_timestamp,
        .ttc_trigger, .trig_type, .acq_ready, .acq_req,
        .trig_push, .trig_rec, .trig_credit_return(trig_credit),
        .trig_num, .trig_timestamp, .error_trig_rate
    );

    event_fifo #(.WIDTH($bits(trig_rec_t)), .DEPTH(`FIFO_DEPTH)) u_trig_fifo (
        .ttc_clk, .rst, .push(trig_push), .push_data(trig_rec), .pop(trig_pop),
        .valid(trig_valid), .head(trig_head), .credit_return(trig_credit),
        .almost_full(trig_fifo_full)
    );

    channel_acq_controller u_acq_ctrl (
        .ttc_clk, .rst, .chan_en, .trig_delay, .acq_req, .acq_ready,
        .chan_dones, .chan_enable, .chan_trig, .acq_push, .acq_rec,
        .acq_credit_return(acq_credit)
    );

    event_fifo #(.WIDTH($bits(acq_rec_t)), .DEPTH(`FIFO_DEPTH)) u_acq_fifo (
        .ttc_clk, .rst, .push(acq_push), .push_data(acq_rec), .pop(acq_pop),
        .valid(acq_valid), .head(acq_head), .credit_return(acq_credit),
        .almost_full(acq_fifo_full)
    );

    trigger_processor u_processor (
        .ttc_clk, .rst, .trig_valid, .trig_head, .acq_valid, .acq_head,
        .trig_pop, .acq_pop, .readout_ready, .readout_done,
        .initiate_readout, .send_empty_event, .ttc_event_num, .ttc_trig_num,
        .ttc_trig_type, .ttc_trig_timestamp, .error_trig_num, .error_trig_type
    );

endmodule

// ==== design/trigger_processor.sv ====
// pairs trigger and acquisition records, cross-checks them and asks for a readout or empty event
`timescale 1ns/1ps
`include "trig_consts.svh"

module trigger_processor (
    input  logic                     ttc_clk,
    input  logic                     rst,
    input  logic                     trig_valid,
    input  trig_pkg::trig_rec_t      trig_head,
    input  logic                     acq_valid,
    input  trig_pkg::acq_rec_t       acq_head,
    output logic                     trig_pop,
    output logic                     acq_pop,
    input  logic                     readout_ready,    // command manager idle
    input  logic                     readout_done,     // answers readout and empty event
    output logic                     initiate_readout,
    output logic                     send_empty_event,
    output logic [`TRIG_NUM_W-1:0]   ttc_event_num,    // from 1
    output logic [`TRIG_NUM_W-1:0]   ttc_trig_num,
    output logic [`TRIG_TYPE_W-1:0]  ttc_trig_type,
    output logic [`TSTAMP_W-1:0]     ttc_trig_timestamp,
    output logic                     error_trig_num,   // sticky
    output logic                     error_trig_type   // sticky
);
    import trig_pkg::*;

    logic take;    // pop both heads this cycle
    logic pending; // request out, no done yet

    assign take     = trig_valid && acq_valid && readout_ready && !pending;
    assign trig_pop = take;
    assign acq_pop  = take;

    // ----------------------------------------------------------------------
    // request and checks
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            pending          <= 1'b0;
            initiate_readout <= 1'b0;
            send_empty_event <= 1'b0;
            ttc_event_num    <= '0;
            error_trig_num   <= 1'b0;
            error_trig_type  <= 1'b0;
        end else begin
            // no channel fired means nothing to read out
            initiate_readout <= take && (acq_head.chan_mask != '0);
            send_empty_event <= take && (acq_head.chan_mask == '0);
            if (take) begin
                pending       <= 1'b1;
                ttc_event_num <= ttc_event_num + 1'b1;
                if (trig_head.trig_num != acq_head.trig_num)
                    error_trig_num <= 1'b1;
                if (trig_head.trig_type != acq_head.trig_type)
                    error_trig_type <= 1'b1;
            end else if (readout_done) begin
                pending <= 1'b0;
            end
        end
    end

    // event fields, held until the next pair
    always_ff @(posedge ttc_clk) begin
        if (take) begin
            ttc_trig_num       <= trig_head.trig_num;
            ttc_trig_type      <= trig_head.trig_type;
            ttc_trig_timestamp <= trig_head.tstamp;
        end
    end

endmodule

// ==== design/channel_acq_controller.sv ====
// delays an accepted trigger, fires the enabled channels, gathers their dones and logs the event
`timescale 1ns/1ps
`include "trig_consts.svh"

module channel_acq_controller (
    input  logic                  ttc_clk,
    input  logic                  rst,
    input  logic [`N_CHAN-1:0]    chan_en,    // sampled at request
    input  logic [`DELAY_W-1:0]   trig_delay, // extra cycles before firing
    input  trig_pkg::acq_req_t    acq_req,
    output logic                  acq_ready,
    input  logic [`N_CHAN-1:0]    chan_dones,
    output logic [`N_CHAN-1:0]    chan_enable,
    output logic [`N_CHAN-1:0]    chan_trig,
    output logic                  acq_push,   // into acquisition fifo
    output trig_pkg::acq_rec_t    acq_rec,
    input  logic                  acq_credit_return
);
    import trig_pkg::*;

    typedef enum logic [2:0] {IDLE, DELAY, FIRE, WAIT_DONE, WRITE} state_t;

    state_t                  state;
    logic [`DELAY_W-1:0]     delay_cnt;
    logic [`N_CHAN-1:0]      mask;      // channels for this event
    logic [`N_CHAN-1:0]      done_seen; // sticky dones
    logic [`TRIG_NUM_W-1:0]  num_q;
    logic [`TRIG_TYPE_W-1:0] type_q;
    logic [`CREDIT_W-1:0]    credits;
    logic                    all_done;

    // an empty mask counts as done straight away
    assign all_done = ((done_seen | chan_dones) & mask) == mask;

    // ----------------------------------------------------------------------
    // fsm
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (acq_req.valid) state <= DELAY;
                DELAY:     if (delay_cnt == '0) state <= FIRE; // lands on delay+2
                FIRE:      state <= WAIT_DONE;
                WAIT_DONE: if (all_done) state <= WRITE;
                WRITE:     state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (state == IDLE && acq_req.valid) begin
            delay_cnt <= trig_delay;
            mask      <= chan_en;
            num_q     <= acq_req.trig_num;
            type_q    <= acq_req.trig_type;
        end else if (state == DELAY) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (rst || state == IDLE)
            done_seen <= '0;
        else if (state == WAIT_DONE)
            done_seen <= done_seen | chan_dones;
    end

    // writer side credits for the acquisition fifo
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            credits <= `CREDIT_W'(`FIFO_DEPTH);
        end else begin
            case ({acq_credit_return, acq_push})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // a request already in flight makes the chain busy
    assign acq_ready   = (state == IDLE) && !acq_req.valid && (credits != '0);
    assign acq_push    = (state == WRITE);
    assign acq_rec     = '{trig_num: num_q, trig_type: type_q, chan_mask: mask};
    assign chan_trig   = (state == FIRE) ? mask : '0; // single cycle pulse
    assign chan_enable = (state == FIRE || state == WAIT_DONE) ? mask : '0;

    // receiver only issues a request while it sees acq_ready
    a_req_when_idle: assert property (@(posedge ttc_clk) disable iff (rst)
        acq_req.valid |-> state == IDLE);

endmodule

// ==== design/trigger_receiver.sv ====
// numbers and time-stamps ttc triggers, accepts them against credits and issues trigger records
`timescale 1ns/1ps
`include "trig_consts.svh"

module trigger_receiver (
    input  logic                     ttc_clk,
    input  logic                     rst,
    input  logic                     rst_trigger_num,       // ttc channel b
    input  logic                     rst_trigger_timestamp, // ttc channel b
    input  logic                     ttc_trigger,
    input  logic [`TRIG_TYPE_W-1:0]  trig_type,
    input  logic                     acq_ready,            // controller idle with space
    output trig_pkg::acq_req_t       acq_req,
    output logic                     trig_push,            // into trigger fifo
    output trig_pkg::trig_rec_t      trig_rec,
    input  logic                     trig_credit_return,   // one per fifo pop
    output logic [`TRIG_NUM_W-1:0]   trig_num,             // counts every trigger
    output logic [`TSTAMP_W-1:0]     trig_timestamp,       // stamp of latest trigger
    output logic                     error_trig_rate       // sticky
);
    import trig_pkg::*;

    logic [`TSTAMP_W-1:0]    tstamp_ctr;  // free running
    logic [`TRIG_TYPE_W-1:0] type_q;
    logic [`CREDIT_W-1:0]    credits;
    logic                    accept;

    assign accept = ttc_trigger && acq_ready && (credits != '0);

    // ----------------------------------------------------------------------
    // counters and acceptance
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst || rst_trigger_timestamp) begin
            tstamp_ctr <= '0;
        end else begin
            tstamp_ctr <= tstamp_ctr + 1'b1;
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            trig_num        <= '0;
            trig_timestamp  <= '0;
            trig_push       <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            trig_push <= accept; // record and request go out next cycle
            if (ttc_trigger) begin
                // a reset arriving with the trigger makes this trigger number 1
                trig_num       <= rst_trigger_num ? `TRIG_NUM_W'(1) : trig_num + 1'b1;
                trig_timestamp <= tstamp_ctr;
                if (!accept)
                    error_trig_rate <= 1'b1; // chain busy, trigger lost
            end else if (rst_trigger_num) begin
                trig_num <= '0;
            end
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (ttc_trigger)
            type_q <= trig_type;
    end

    // writer side credits for the trigger fifo
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            credits <= `CREDIT_W'(`FIFO_DEPTH);
        end else begin
            case ({trig_credit_return, accept})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign trig_rec = '{tstamp: trig_timestamp, trig_num: trig_num, trig_type: type_q};
    assign acq_req  = '{valid: trig_push, trig_num: trig_num, trig_type: type_q};

    // every returned credit was spent on an earlier push
    a_push_credit: assert property (@(posedge ttc_clk) disable iff (rst)
        trig_credit_return |-> credits != `CREDIT_W'(`FIFO_DEPTH));

endmodule

// ==== design/event_fifo.sv ====
// small show-ahead fifo for one record type, returns a credit to its writer on every pop
`timescale 1ns/1ps

module event_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             ttc_clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic             valid,         // head holds data
    output logic [WIDTH-1:0] head,          // show ahead
    output logic             credit_return, // one cycle per pop
    output logic             almost_full    // half depth or more
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_pop;

    assign do_pop = pop && valid;

    always_ff @(posedge ttc_clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= do_pop;
        end
    end

    assign valid       = (count != '0);
    assign head        = mem[rd_ptr];
    assign almost_full = (count >= DEPTH / 2);

    // writer credits keep both of these from ever firing
    a_no_overflow: assert property (@(posedge ttc_clk) disable iff (rst)
        push |-> count < DEPTH);
    a_no_underflow: assert property (@(posedge ttc_clk) disable iff (rst)
        pop |-> valid);

endmodule

// ==== design/trig_pkg.sv ====
// record types passed between receiver, acquisition controller, fifos and processor
`include "trig_consts.svh"

package trig_pkg;

    // trigger fifo entry, written by the receiver
    typedef struct packed {
        logic [`TSTAMP_W-1:0]    tstamp;    // timestamp at trigger
        logic [`TRIG_NUM_W-1:0]  trig_num;  // starts at 1
        logic [`TRIG_TYPE_W-1:0] trig_type;
    } trig_rec_t;

    // acquisition fifo entry, written once all enabled channels are done
    typedef struct packed {
        logic [`TRIG_NUM_W-1:0]  trig_num;
        logic [`TRIG_TYPE_W-1:0] trig_type;
        logic [`N_CHAN-1:0]      chan_mask; // channels actually fired
    } acq_rec_t;

    // receiver to controller handoff
    typedef struct packed {
        logic                    valid; // one cycle per accepted trigger
        logic [`TRIG_NUM_W-1:0]  trig_num;
        logic [`TRIG_TYPE_W-1:0] trig_type;
    } acq_req_t;

endpackage

// ==== design/trig_consts.svh ====
// widths, fifo depth and channel count shared by the trigger path; include before use
`ifndef TRIG_CONSTS_SVH
`define TRIG_CONSTS_SVH

// ----------------------------------------------------------------------
// channel side
// ----------------------------------------------------------------------
`define N_CHAN 5 // channel fpgas driven by the trigger path

// ----------------------------------------------------------------------
// record fields
// ----------------------------------------------------------------------
`define TRIG_NUM_W  24 // global trigger number
`define TSTAMP_W    44 // ttc clock tick count
`define TRIG_TYPE_W 3  // muon fill, laser, pedestal ...
`define DELAY_W     4  // programmable trigger delay in ttc cycles

// ----------------------------------------------------------------------
// event fifos
// ----------------------------------------------------------------------
`define FIFO_DEPTH 16 // entries per fifo, also the starting credit count

// credit counters must reach FIFO_DEPTH itself
`define CREDIT_W ($clog2(`FIFO_DEPTH + 1))

`endif
